/* compile.f */
+incdir+logic
logic/cache_pkg.sv
logic/plru_table.sv
logic/tag_array.sv
logic/data_array.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cache_tb -f compile.f -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/cache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1

/* dv/cache_tb.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_tb;

    localparam logic [31:0] SEED       = 32'h9bf9;
    localparam int          WAIT_LIMIT = 200;
    localparam int          POOL_TAGS  = 8;
    localparam int          POOL_SETS  = 4;
    localparam int          NUM_RANDOM = 400;

    logic                     clk;
    logic                     rst_n;
    logic                     cpu_read_req;
    logic                     cpu_write_req;
    logic [`CACHE_ADDR_W-1:0] cpu_addr;
    logic [`CACHE_STRB_W-1:0] cpu_wmask;
    logic [`CACHE_DATA_W-1:0] cpu_wdata;
    logic                     cpu_data_ok;
    logic [`CACHE_DATA_W-1:0] cpu_rdata;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    logic [`CACHE_LINE_W-1:0] mem_wdata;
    logic [`CACHE_LINE_W-1:0] mem_rdata;
    logic                     mem_req_r;
    logic                     mem_req_w;
    logic                     mem_ready;
    logic                     mem_stall;

    int          errors       = 0;
    int          checks       = 0;
    int          mem_busy     = 0;
    logic        pending_fill = 1'b0;
    logic [31:0] rand_state   = SEED;
    logic [31:0] stall_state  = ~SEED;
    logic [31:0] cur_addr     = '0;
    logic [31:0] prev_addr    = '0;
    logic        prev_req_r   = 1'b0;
    logic        prev_req_w   = 1'b0;
    logic        prev_ready   = 1'b0;
    // reference memory, one 64-bit word per aligned address
    logic [63:0] model [logic [31:0]];

    cache_top i_dut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .cpu_read_req_i   (cpu_read_req),
        .cpu_write_req_i  (cpu_write_req),
        .cpu_addr_i       (cpu_addr),
        .cpu_wmask_i      (cpu_wmask),
        .cpu_write_data_i (cpu_wdata),
        .cpu_data_ok_o    (cpu_data_ok),
        .cpu_read_data_o  (cpu_rdata),
        .mem_req_addr_o   (mem_addr),
        .mem_w_data_o     (mem_wdata),
        .mem_req_r_o      (mem_req_r),
        .mem_req_w_o      (mem_req_w),
        .mem_r_data_i     (mem_rdata),
        .mem_req_ready_i  (mem_ready)
    );

    mem_model i_mem (
        .clk_i    (clk),
        .req_r_i  (mem_req_r),
        .req_w_i  (mem_req_w),
        .addr_i   (mem_addr),
        .w_data_i (mem_wdata),
        .stall_i  (mem_stall),
        .r_data_o (mem_rdata),
        .ready_o  (mem_ready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = lcg_next(rand_state);
        return rand_state ^ (rand_state >> 16);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int half);
        return {22'(tag), 6'(index), 1'(half), 3'b000};
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        if (model.exists(addr)) begin
            return model[addr];
        end
        return {addr, addr};
    endfunction

    task automatic merge_write(input logic [31:0] addr, input logic [7:0] mask,
                               input logic [63:0] data);
        logic [63:0] word;
        word = expected_word(addr);
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        model[addr] = word;
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // one request, held until data_ok, dropped on the following edge
    task automatic do_access(input logic is_write, input logic [31:0] addr,
                             input logic [7:0] mask, input logic [63:0] data,
                             output logic [63:0] rdata, output int latency);
        int waited;
        @(posedge clk);
        cur_addr = addr;
        cpu_read_req  <= !is_write;
        cpu_write_req <= is_write;
        cpu_addr      <= addr;
        cpu_wmask     <= mask;
        cpu_wdata     <= data;
        waited = 0;
        @(negedge clk);
        while (!cpu_data_ok && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_data_ok) begin
            $display("timeout: no data_ok after %0d cycles for address %h", WAIT_LIMIT, addr);
            errors++;
            end_run();
        end else begin
            check_value("writeback not followed by a fill", 64'(pending_fill), 64'd0);
            rdata   = cpu_rdata;
            latency = waited;
            @(posedge clk);
            cpu_read_req  <= 1'b0;
            cpu_write_req <= 1'b0;
        end
    endtask

    task automatic read_and_check(input logic [31:0] addr, input logic expect_hit);
        logic [63:0] rdata;
        int          latency;
        int          busy_before;
        busy_before = mem_busy;
        do_access(1'b0, addr, 8'h00, 64'd0, rdata, latency);
        check_value($sformatf("read data at %h", addr), rdata, expected_word(addr));
        if (mem_busy == busy_before) begin
            check_value("read hit latency", 64'(latency), 64'd0);
        end else if (expect_hit) begin
            check_value("memory cycles on an expected hit", 64'(mem_busy - busy_before), 64'd0);
        end
    endtask

    task automatic write_and_check(input logic [31:0] addr, input logic [7:0] mask,
                                   input logic [63:0] data, input logic expect_hit);
        logic [63:0] rdata;
        int          latency;
        int          busy_before;
        busy_before = mem_busy;
        do_access(1'b1, addr, mask, data, rdata, latency);
        merge_write(addr, mask, data);
        if (mem_busy == busy_before) begin
            check_value("write hit latency", 64'(latency), 64'd1);
        end else if (expect_hit) begin
            check_value("memory cycles on an expected hit", 64'(mem_busy - busy_before), 64'd0);
        end
    endtask

    always @(posedge clk) begin
        stall_state = lcg_next(stall_state);
        mem_stall <= (stall_state[17:16] == 2'b00);
    end

    // memory port watcher
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            check_value("memory read and write together", 64'(mem_req_r & mem_req_w), 64'd0);
            if ((prev_req_r || prev_req_w) && !prev_ready) begin
                check_value("stalled request kind", 64'({mem_req_r, mem_req_w}),
                            64'({prev_req_r, prev_req_w}));
                check_value("stalled request address", 64'(mem_addr), 64'(prev_addr));
            end
            if (mem_req_r || mem_req_w) begin
                mem_busy++;
                check_value("line alignment", 64'(mem_addr[3:0]), 64'd0);
            end
            if (mem_req_w && mem_ready) begin
                check_value("writeback of the requested tag",
                            64'(mem_addr[31:10] == cur_addr[31:10]), 64'd0);
                pending_fill = 1'b1;
            end
            if (mem_req_r) begin
                check_value("fill address", 64'(mem_addr), 64'({cur_addr[31:4], 4'h0}));
                if (mem_ready) begin
                    pending_fill = 1'b0;
                end
            end
            prev_req_r = mem_req_r;
            prev_req_w = mem_req_w;
            prev_ready = mem_ready;
            prev_addr  = mem_addr;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] mask_r;
        logic [63:0] data;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cpu_read_req  = 1'b0;
        cpu_write_req = 1'b0;
        cpu_addr      = '0;
        cpu_wmask     = '0;
        cpu_wdata     = '0;
        mem_stall     = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value("data_ok after reset", 64'(cpu_data_ok), 64'd0);
            check_value("memory request after reset", 64'(mem_req_r | mem_req_w), 64'd0);
        end

        // hit timing in a set the random mix never touches
        read_and_check(make_addr(7, 20, 0), 1'b0);
        read_and_check(make_addr(7, 20, 1), 1'b1);
        write_and_check(make_addr(7, 20, 1), 8'h3c, 64'h0123_4567_89ab_cdef, 1'b1);
        read_and_check(make_addr(7, 20, 1), 1'b1);

        // fill set 10, touch A again, a fifth line must not evict A
        for (int t = 1; t <= 4; t++) begin
            read_and_check(make_addr(t, 10, 0), 1'b0);
        end
        read_and_check(make_addr(1, 10, 0), 1'b1);
        read_and_check(make_addr(5, 10, 0), 1'b0);
        read_and_check(make_addr(1, 10, 1), 1'b1);

        // small pool, so evictions of dirty lines are common
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r      = next_rand();
            addr   = make_addr(256 + int'(r[23:16]) % POOL_TAGS,
                               32 + int'(r[27:24]) % POOL_SETS, int'(r[28]));
            mask_r = next_rand();
            data   = {next_rand(), next_rand()};
            if (r[29]) begin
                write_and_check(addr, mask_r[7:0], data, 1'b0);
            end else begin
                read_and_check(addr, 1'b0);
            end
        end
        end_run();
    end

endmodule

/* dv/mem_model.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module mem_model (
    input  logic                     clk_i,
    input  logic                     req_r_i,
    input  logic                     req_w_i,
    input  logic [`CACHE_ADDR_W-1:0] addr_i,
    input  logic [`CACHE_LINE_W-1:0] w_data_i,
    input  logic                     stall_i,
    output logic [`CACHE_LINE_W-1:0] r_data_o,
    output logic                     ready_o
);

    // only lines that were written back live here
    logic [`CACHE_LINE_W-1:0] lines [logic [`CACHE_ADDR_W-1:0]];

    // untouched memory holds each word's own address in both halves
    function automatic logic [`CACHE_LINE_W-1:0] line_at(input logic [`CACHE_ADDR_W-1:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        if (lines.exists(addr)) begin
            return lines[addr];
        end
        lo = addr;
        hi = addr + 32'd8;
        return {hi, hi, lo, lo};
    endfunction

    assign ready_o = (req_r_i | req_w_i) & ~stall_i;

    // read data settles mid cycle, ahead of the ready edge
    always @(negedge clk_i) begin
        r_data_o <= line_at(addr_i);
    end

    always @(posedge clk_i) begin
        if (req_w_i && ready_o) begin
            lines[addr_i] = w_data_i;
        end
    end

endmodule

/* logic/cache_top.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // cpu
    input  logic                      cpu_read_req_i,
    input  logic                      cpu_write_req_i,
    input  logic [`CACHE_ADDR_W-1:0]  cpu_addr_i,
    input  logic [`CACHE_STRB_W-1:0]  cpu_wmask_i,
    input  logic [`CACHE_DATA_W-1:0]  cpu_write_data_i,
    output logic                      cpu_data_ok_o,
    output logic [`CACHE_DATA_W-1:0]  cpu_read_data_o,
    // memory
    output logic [`CACHE_ADDR_W-1:0]  mem_req_addr_o,
    output logic [`CACHE_LINE_W-1:0]  mem_w_data_o,
    output logic                      mem_req_r_o,
    output logic                      mem_req_w_o,
    input  logic [`CACHE_LINE_W-1:0]  mem_r_data_i,
    input  logic                      mem_req_ready_i
);

    logic                         hit;
    cache_pkg::way_t              hit_way;
    logic                         victim_dirty;
    cache_pkg::tag_t              victim_tag;
    cache_pkg::way_t              victim_way;
    cache_pkg::line_t             rd_line;
    cache_pkg::index_t            index;
    cache_pkg::way_t              sel_way;
    cache_pkg::tag_t              tag;
    logic                         tag_wen;
    logic                         dirty_wen;
    logic                         dirty_val;
    logic                         data_wen;
    logic [`CACHE_LINE_W/8-1:0]   data_bmask;
    cache_pkg::line_t             wr_line;
    logic                         lru_upd;
    cache_pkg::way_t              lru_way;

    cache_ctrl i_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .cpu_read_req_i   (cpu_read_req_i),
        .cpu_write_req_i  (cpu_write_req_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_wmask_i      (cpu_wmask_i),
        .cpu_write_data_i (cpu_write_data_i),
        .cpu_data_ok_o    (cpu_data_ok_o),
        .cpu_read_data_o  (cpu_read_data_o),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .victim_dirty_i   (victim_dirty),
        .victim_tag_i     (victim_tag),
        .victim_way_i     (victim_way),
        .rd_line_i        (rd_line),
        .index_o          (index),
        .sel_way_o        (sel_way),
        .tag_o            (tag),
        .tag_wen_o        (tag_wen),
        .dirty_wen_o      (dirty_wen),
        .dirty_val_o      (dirty_val),
        .data_wen_o       (data_wen),
        .data_bmask_o     (data_bmask),
        .wr_line_o        (wr_line),
        .lru_upd_o        (lru_upd),
        .lru_way_o        (lru_way),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_w_data_o     (mem_w_data_o),
        .mem_req_r_o      (mem_req_r_o),
        .mem_req_w_o      (mem_req_w_o),
        .mem_r_data_i     (mem_r_data_i),
        .mem_req_ready_i  (mem_req_ready_i)
    );

    tag_array i_tags (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .index_i        (index),
        .tag_i          (tag),
        .sel_way_i      (sel_way),
        .tag_wen_i      (tag_wen),
        .dirty_wen_i    (dirty_wen),
        .dirty_val_i    (dirty_val),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    data_array i_data (
        .clk_i     (clk_i),
        .index_i   (index),
        .sel_way_i (sel_way),
        .wen_i     (data_wen),
        .bmask_i   (data_bmask),
        .line_i    (wr_line),
        .line_o    (rd_line)
    );

    plru_table i_plru (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .index_i  (index),
        .upd_i    (lru_upd),
        .way_i    (lru_way),
        .victim_o (victim_way)
    );

    // a filled line must hit in its own way right after the fill edge
    a_fill_hits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (i_ctrl.state_q == cache_pkg::ST_LINEFILL && mem_req_ready_i)
        |=> (hit && hit_way == sel_way));

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // cpu
    input  logic                      cpu_read_req_i,
    input  logic                      cpu_write_req_i,
    input  logic [`CACHE_ADDR_W-1:0]  cpu_addr_i,
    input  logic [`CACHE_STRB_W-1:0]  cpu_wmask_i,
    input  logic [`CACHE_DATA_W-1:0]  cpu_write_data_i,
    output logic                      cpu_data_ok_o,
    output logic [`CACHE_DATA_W-1:0]  cpu_read_data_o,
    // tag array
    input  logic                      hit_i,
    input  cache_pkg::way_t           hit_way_i,
    input  logic                      victim_dirty_i,
    input  cache_pkg::tag_t           victim_tag_i,
    // replacement
    input  cache_pkg::way_t           victim_way_i,
    // data array
    input  cache_pkg::line_t          rd_line_i,
    // array control
    output cache_pkg::index_t         index_o,
    output cache_pkg::way_t           sel_way_o,
    output cache_pkg::tag_t           tag_o,
    output logic                      tag_wen_o,
    output logic                      dirty_wen_o,
    output logic                      dirty_val_o,
    output logic                      data_wen_o,
    output logic [`CACHE_LINE_W/8-1:0] data_bmask_o,
    output cache_pkg::line_t          wr_line_o,
    output logic                      lru_upd_o,
    output cache_pkg::way_t           lru_way_o,
    // memory
    output logic [`CACHE_ADDR_W-1:0]  mem_req_addr_o,
    output logic [`CACHE_LINE_W-1:0]  mem_w_data_o,
    output logic                      mem_req_r_o,
    output logic                      mem_req_w_o,
    input  logic [`CACHE_LINE_W-1:0]  mem_r_data_i,
    input  logic                      mem_req_ready_i
);

    cache_pkg::cache_state_e   state_q;
    cache_pkg::cache_state_e   state_d;

    // captured request
    logic [`CACHE_ADDR_W-1:0]  addr_q;
    logic [`CACHE_DATA_W-1:0]  wdata_q;
    logic [`CACHE_STRB_W-1:0]  wmask_q;
    cache_pkg::way_t           way_q;

    logic                      cpu_req;
    logic                      in_cmp;
    logic                      in_wline;
    logic                      in_rline;
    logic                      cmp_leave;
    logic                      fill_done;
    logic                      half;
    cache_pkg::tag_t           cpu_tag;
    cache_pkg::index_t         cpu_index;
    cache_pkg::tag_t           tag_q;
    cache_pkg::index_t         index_q;
    logic [`CACHE_LINE_W/8-1:0] wline_bmask;

    assign cpu_req   = cpu_read_req_i | cpu_write_req_i;
    assign in_cmp    = (state_q == cache_pkg::ST_CMP);
    assign in_wline  = (state_q == cache_pkg::ST_WLINE);
    assign in_rline  = (state_q == cache_pkg::ST_RLINE);
    // a read hit stays in compare, everything else moves on
    assign cmp_leave = in_cmp & cpu_req & ~(hit_i & cpu_read_req_i);
    assign fill_done = (state_q == cache_pkg::ST_LINEFILL) & mem_req_ready_i;

    assign cpu_tag   = cpu_addr_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign cpu_index = cpu_addr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign tag_q     = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign index_q   = addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::ST_CMP: begin
                if (cpu_req) begin
                    if (hit_i) begin
                        state_d = cpu_write_req_i ? cache_pkg::ST_WLINE : cache_pkg::ST_CMP;
                    end else begin
                        state_d = victim_dirty_i ? cache_pkg::ST_WMEM : cache_pkg::ST_LINEFILL;
                    end
                end
            end
            cache_pkg::ST_WMEM: begin
                if (mem_req_ready_i) begin
                    state_d = cache_pkg::ST_LINEFILL;
                end
            end
            cache_pkg::ST_LINEFILL: begin
                if (mem_req_ready_i) begin
                    state_d = cpu_write_req_i ? cache_pkg::ST_WLINE : cache_pkg::ST_RLINE;
                end
            end
            default: state_d = cache_pkg::ST_CMP;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= cache_pkg::ST_CMP;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmp_leave) begin
            addr_q  <= cpu_addr_i;
            wdata_q <= cpu_write_data_i;
            wmask_q <= cpu_wmask_i;
            way_q   <= sel_way_o;
        end
    end

    // compare looks at the live request, later states at the captured one
    assign index_o   = in_cmp ? cpu_index : index_q;
    assign tag_o     = in_cmp ? cpu_tag : tag_q;
    assign sel_way_o = in_cmp ? (hit_i ? hit_way_i : victim_way_i) : way_q;

    // byte mask onto the addressed half
    assign wline_bmask = addr_q[`CACHE_OFFSET_W-1] ? {wmask_q, {`CACHE_STRB_W{1'b0}}}
                                                   : {{`CACHE_STRB_W{1'b0}}, wmask_q};

    assign tag_wen_o    = fill_done;
    assign dirty_wen_o  = in_wline;
    assign dirty_val_o  = in_wline;
    assign data_wen_o   = fill_done | in_wline;
    assign data_bmask_o = in_wline ? wline_bmask : {(`CACHE_LINE_W/8){1'b1}};
    assign wr_line_o    = in_wline ? {2{wdata_q}} : mem_r_data_i;

    // hits touch the tree in compare, misses on the fill edge
    assign lru_upd_o = (in_cmp & cpu_req & hit_i) | fill_done;
    assign lru_way_o = sel_way_o;

    assign mem_req_w_o    = (state_q == cache_pkg::ST_WMEM);
    assign mem_req_r_o    = (state_q == cache_pkg::ST_LINEFILL);
    assign mem_req_addr_o = mem_req_w_o ? {victim_tag_i, index_q, {`CACHE_OFFSET_W{1'b0}}}
                                        : {tag_q, index_q, {`CACHE_OFFSET_W{1'b0}}};
    assign mem_w_data_o   = rd_line_i;

    assign half            = in_cmp ? cpu_addr_i[`CACHE_OFFSET_W-1] : addr_q[`CACHE_OFFSET_W-1];
    assign cpu_read_data_o = half ? rd_line_i[`CACHE_LINE_W-1 -: `CACHE_DATA_W]
                                  : rd_line_i[`CACHE_DATA_W-1:0];
    assign cpu_data_ok_o   = (in_cmp & cpu_read_req_i & hit_i) | in_wline | in_rline;

    a_mem_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_req_r_o && mem_req_w_o));

    // the way chosen in compare stays the replacement victim for the whole miss
    a_way_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == cache_pkg::ST_WMEM || state_q == cache_pkg::ST_LINEFILL)
        |-> (way_q == victim_way_i));

endmodule

/* logic/data_array.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module data_array (
    input  logic                       clk_i,
    input  cache_pkg::index_t          index_i,
    input  cache_pkg::way_t            sel_way_i,
    input  logic                       wen_i,
    input  logic [`CACHE_LINE_W/8-1:0] bmask_i,
    input  cache_pkg::line_t           line_i,
    output cache_pkg::line_t           line_o
);

    // four ways by all sets
    cache_pkg::line_t mem [`CACHE_WAYS][`CACHE_SETS];

    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            for (int b = 0; b < `CACHE_LINE_W/8; b++) begin
                if (bmask_i[b]) begin
                    mem[sel_way_i][index_i][b*8 +: 8] <= line_i[b*8 +: 8];
                end
            end
        end
    end

    // read is combinational, so a hit answers in the request cycle
    assign line_o = mem[sel_way_i][index_i];

endmodule

/* logic/tag_array.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module tag_array (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  cache_pkg::index_t  index_i,
    input  cache_pkg::tag_t    tag_i,
    input  cache_pkg::way_t    sel_way_i,
    input  logic               tag_wen_i,
    input  logic               dirty_wen_i,
    input  logic               dirty_val_i,
    output logic               hit_o,
    output cache_pkg::way_t    hit_way_o,
    input  cache_pkg::way_t    victim_way_i,
    output logic               victim_dirty_o,
    output cache_pkg::tag_t    victim_tag_o
);

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] dirty_q;
    cache_pkg::tag_t                         tag_mem [`CACHE_WAYS][`CACHE_SETS];
    cache_pkg::way_mask_t                    way_hit;

    // compare all ways of the set at once
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid_q[index_i][w] && (tag_mem[w][index_i] == tag_i);
        end
    end

    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way_o = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit_o = |way_hit;

    // dirty implies valid, so no valid check here
    assign victim_dirty_o = dirty_q[index_i][victim_way_i];
    assign victim_tag_o   = tag_mem[victim_way_i][index_i];

    always_ff @(posedge clk_i) begin
        if (tag_wen_i) begin
            tag_mem[sel_way_i][index_i] <= tag_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            // fresh line comes in clean
            if (tag_wen_i) begin
                valid_q[index_i][sel_way_i] <= 1'b1;
                dirty_q[index_i][sel_way_i] <= 1'b0;
            end
            if (dirty_wen_i) begin
                dirty_q[index_i][sel_way_i] <= dirty_val_i;
            end
        end
    end

    // a fill never installs a tag that is already present in the set
    a_one_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(way_hit));

endmodule

/* logic/plru_table.sv */
`timescale 1ns/100ps
`include "cache_defines.svh"

module plru_table (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  cache_pkg::index_t index_i,
    input  logic              upd_i,
    input  cache_pkg::way_t   way_i,
    output cache_pkg::way_t   victim_o
);

    // bit 0 picks the pair, bit 1 ways 0/1, bit 2 ways 2/3
    logic [`CACHE_SETS-1:0][2:0] tree_q;
    logic [2:0]                  bits;

    assign bits = tree_q[index_i];

    always_comb begin
        if (bits[0]) begin
            victim_o = {1'b1, bits[2]};
        end else begin
            victim_o = {1'b0, bits[1]};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tree_q <= '0;
        end else if (upd_i) begin
            // point every bit on the path away from the accessed way
            tree_q[index_i][0] <= ~way_i[1];
            if (way_i[1]) begin
                tree_q[index_i][2] <= ~way_i[0];
            end else begin
                tree_q[index_i][1] <= ~way_i[0];
            end
        end
    end

endmodule

/* logic/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

    // controller states
    typedef enum logic [2:0] {
        ST_CMP,
        ST_WMEM,
        ST_LINEFILL,
        ST_WLINE,
        ST_RLINE
    } cache_state_e;

    typedef logic [`CACHE_WAY_W-1:0]   way_t;
    typedef logic [`CACHE_WAYS-1:0]    way_mask_t;
    typedef logic [`CACHE_LINE_W-1:0]  line_t;
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;

endpackage

/* logic/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// cpu side
`define CACHE_ADDR_W   32
`define CACHE_DATA_W   64
`define CACHE_STRB_W   8

// one line per memory transfer
`define CACHE_LINE_W   128

// geometry
`define CACHE_WAYS     4
`define CACHE_WAY_W    2
`define CACHE_SETS     64
`define CACHE_INDEX_W  6
`define CACHE_OFFSET_W 4

// address minus index and offset
`define CACHE_TAG_W    22

`endif
